//--- src.f
design/driver_pkg.sv
design/driver_regs.sv
design/time_cnt_generator.sv
design/intensity_modulator.sv
design/pwm_generator.sv
design/transducer_driver_top.sv
testbench/tb_transducer_driver.sv

//--- Bender.yml
package:
  name: transducer_driver

sources:
  - design/driver_pkg.sv
  - design/driver_regs.sv
  - design/time_cnt_generator.sv
  - design/intensity_modulator.sv
  - design/pwm_generator.sv
  - design/transducer_driver_top.sv
  - target: test
    files:
      - testbench/tb_transducer_driver.sv

//--- testbench/tb_transducer_driver.sv
`timescale 1ns/1ps
module tb_transducer_driver;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 10;
  localparam int NUM_ROWS = 10;
  localparam int PERIOD_CYCLES = 256;
  localparam int RESET_CHECK_CYCLES = 260;
  localparam int UPDATE_WAIT_CYCLES = 300;
  localparam int SYNC_AT_CYCLE = 100;
  localparam longint WATCHDOG_NS =
    longint'(NUM_ROWS) * 4 * PERIOD_CYCLES * CLK_PERIOD + RESET_CYCLES * CLK_PERIOD;

  // One stimulus row with its expected pulse widths.
  typedef struct packed {
    driver_pkg::intensity_t [driver_pkg::NUM_CHANNELS-1:0]   intensity;
    driver_pkg::phase_t [driver_pkg::NUM_CHANNELS-1:0]       phase;
    driver_pkg::pulse_width_t [driver_pkg::NUM_CHANNELS-1:0] exp_width;
    logic [7:0] mod_value;
    logic       enable;
    logic       do_sync;
  } test_row_t;

  logic                                clk = 1'b0;
  logic                                arst_n;
  logic                                sync;
  logic                                wr_en;
  driver_pkg::addr_t                   wr_addr;
  driver_pkg::data_t                   wr_data;
  logic [driver_pkg::NUM_CHANNELS-1:0] pwm_out;
  driver_pkg::time_cnt_t               time_cnt;
  logic                                update;

  test_row_t rows [NUM_ROWS];
  logic [15:0] lfsr_state = 16'd38;

  transducer_driver_top dut (
    .clk     (clk),
    .arst_n  (arst_n),
    .sync    (sync),
    .wr_en   (wr_en),
    .wr_addr (wr_addr),
    .wr_data (wr_data),
    .pwm_out (pwm_out),
    .time_cnt(time_cnt),
    .update  (update)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // Taps 16, 14, 13, 11.
  function automatic logic lfsr_next_bit();
    logic fb;
    fb = lfsr_state[15] ^ lfsr_state[13] ^ lfsr_state[12] ^ lfsr_state[10];
    lfsr_state = {lfsr_state[14:0], fb};
    return fb;
  endfunction

  function automatic logic [7:0] random_byte();
    logic [7:0] value;
    for (int i = 0; i < 8; i++) begin
      value[i] = lfsr_next_bit();
    end
    return value;
  endfunction

  function automatic int scaled_width(input int intensity, input int mod_value,
                                      input logic enable);
    int product;
    product = intensity * (mod_value + 1);
    return enable ? product / 256 : 0;
  endfunction

  // High when time_cnt sits inside the window centred on the phase.
  function automatic logic expected_level(input int width, input int phase, input int tc);
    int rise;
    int offset;
    rise = (phase - width / 2 + 256) % 256;
    offset = (tc - rise + 256) % 256;
    return offset < width;
  endfunction

  task automatic report_mismatch(input string msg);
    $display("FAIL at %0t: %s", $time, msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Stopping at the first error.");
  endtask

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("SIMULATION FAILED");
    $fatal(1, "Run aborted.");
  endtask

  task automatic set_channel(input int r, input int ch, input int intensity,
                             input int phase, input int width);
    rows[r].intensity[ch] = driver_pkg::intensity_t'(intensity);
    rows[r].phase[ch]     = driver_pkg::phase_t'(phase);
    rows[r].exp_width[ch] = driver_pkg::pulse_width_t'(width);
  endtask

  task automatic set_globals(input int r, input int mod_value, input logic enable,
                             input logic do_sync);
    rows[r].mod_value = 8'(mod_value);
    rows[r].enable    = enable;
    rows[r].do_sync   = do_sync;
  endtask

  task automatic build_table();
    int inten;
    int phs;
    // Full scale rows with windows that wrap below 0 and past 255.
    set_channel(0, 0, 40, 128, 40);
    set_channel(0, 1, 100, 10, 100);
    set_channel(0, 2, 255, 250, 255);
    set_channel(0, 3, 8, 3, 8);
    set_globals(0, 255, 1'b1, 1'b0);
    set_channel(1, 0, 200, 0, 100);
    set_channel(1, 1, 200, 64, 100);
    set_channel(1, 2, 200, 128, 100);
    set_channel(1, 3, 200, 192, 100);
    set_globals(1, 127, 1'b1, 1'b0);
    set_channel(2, 0, 255, 30, 63);
    set_channel(2, 1, 128, 90, 32);
    set_channel(2, 2, 1, 150, 0);
    set_channel(2, 3, 0, 245, 0);
    set_globals(2, 63, 1'b1, 1'b0);
    set_channel(3, 0, 255, 12, 0);
    set_channel(3, 1, 200, 34, 0);
    set_channel(3, 2, 100, 56, 0);
    set_channel(3, 3, 3, 78, 0);
    set_globals(3, 0, 1'b1, 1'b0);
    // Output disabled.
    set_channel(4, 0, 255, 0, 0);
    set_channel(4, 1, 128, 100, 0);
    set_channel(4, 2, 64, 200, 0);
    set_channel(4, 3, 200, 250, 0);
    set_globals(4, 255, 1'b0, 1'b0);
    set_channel(5, 0, 90, 200, 70);
    set_channel(5, 1, 180, 20, 141);
    set_channel(5, 2, 45, 100, 35);
    set_channel(5, 3, 255, 255, 200);
    set_globals(5, 200, 1'b1, 1'b1);
    for (int r = 6; r < NUM_ROWS; r++) begin
      set_globals(r, random_byte(), 1'b1, r == 8);
      for (int ch = 0; ch < driver_pkg::NUM_CHANNELS; ch++) begin
        inten = random_byte();
        phs = random_byte();
        set_channel(r, ch, inten, phs, scaled_width(inten, rows[r].mod_value, 1'b1));
      end
    end
  endtask

  task automatic write_reg(input driver_pkg::addr_t addr, input driver_pkg::data_t data);
    @(negedge clk);
    wr_en   = 1'b1;
    wr_addr = addr;
    wr_data = data;
  endtask

  task automatic apply_row(input int r);
    for (int ch = 0; ch < driver_pkg::NUM_CHANNELS; ch++) begin
      write_reg(driver_pkg::addr_t'(ch), {rows[r].intensity[ch], rows[r].phase[ch]});
    end
    // Unmapped address that aliases channel 1 in its low bits.
    write_reg(8'd5, 16'hffff);
    write_reg(driver_pkg::MOD_ADDR, {8'd0, rows[r].mod_value});
    write_reg(driver_pkg::CTRL_ADDR, {15'd0, rows[r].enable});
    @(negedge clk);
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
  endtask

  task automatic wait_for_update();
    int waited;
    waited = 0;
    @(negedge clk);
    while (!update) begin
      if (waited >= UPDATE_WAIT_CYCLES) begin
        abort_run("No update pulse arrived within the expected number of cycles.");
      end else begin
        @(negedge clk);
        waited++;
      end
    end
  endtask

  task automatic check_reset_state();
    int prev_tc;
    assert (time_cnt == 8'd0 && pwm_out == '0)
      else report_mismatch($sformatf("after reset time_cnt %0d pwm_out %b",
                                     time_cnt, pwm_out));
    prev_tc = 0;
    repeat (RESET_CHECK_CYCLES) begin
      @(negedge clk);
      assert (time_cnt == 8'((prev_tc + 1) % 256))
        else report_mismatch($sformatf("time_cnt %0d after %0d", time_cnt, prev_tc));
      assert (pwm_out == '0)
        else report_mismatch($sformatf("pwm_out %b after reset", pwm_out));
      prev_tc = time_cnt;
    end
  endtask

  // Entered at the update cycle with time_cnt at 255.
  task automatic check_period(input int r);
    int prev_tc;
    logic sync_sent;
    logic exp_bit;
    sync_sent = 1'b0;
    @(negedge clk);
    assert (time_cnt == 8'd0)
      else report_mismatch($sformatf("row %0d period starts at time_cnt %0d", r, time_cnt));
    prev_tc = 0;
    for (int i = 0; i < PERIOD_CYCLES; i++) begin
      @(negedge clk);
      if (sync_sent) begin
        sync = 1'b0;
        assert (time_cnt == 8'd0)
          else report_mismatch($sformatf("row %0d time_cnt %0d after sync", r, time_cnt));
      end else begin
        assert (time_cnt == 8'((prev_tc + 1) % 256))
          else report_mismatch($sformatf("row %0d time_cnt %0d after %0d",
                                         r, time_cnt, prev_tc));
      end
      // The registered output reflects the previous count.
      for (int ch = 0; ch < driver_pkg::NUM_CHANNELS; ch++) begin
        exp_bit = expected_level(rows[r].exp_width[ch], rows[r].phase[ch], prev_tc);
        assert (pwm_out[ch] == exp_bit)
          else report_mismatch($sformatf("row %0d channel %0d time_cnt %0d pwm_out %0b exp %0b",
                                         r, ch, prev_tc, pwm_out[ch], exp_bit));
      end
      prev_tc = time_cnt;
      sync_sent = 1'b0;
      if (rows[r].do_sync && i == SYNC_AT_CYCLE) begin
        sync = 1'b1;
        sync_sent = 1'b1;
      end
    end
  endtask

  // Update must mark the last count of every period.
  always @(negedge clk) begin
    if (arst_n) begin
      assert (update == (time_cnt == 8'd255))
        else report_mismatch($sformatf("update %0b at time_cnt %0d", update, time_cnt));
    end
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Test timed out before all rows were checked.");
    $display("SIMULATION FAILED");
    $fatal(1, "Watchdog expired.");
  end

  initial begin
    arst_n  = 1'b0;
    sync    = 1'b0;
    wr_en   = 1'b0;
    wr_addr = '0;
    wr_data = '0;
    build_table();
    repeat (RESET_CYCLES) @(negedge clk);
    arst_n = 1'b1;
    check_reset_state();
    for (int r = 0; r < NUM_ROWS; r++) begin
      apply_row(r);
      // Settings are sampled after the first update and active after the second.
      wait_for_update();
      wait_for_update();
      check_period(r);
    end
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

//--- design/transducer_driver_top.sv
`timescale 1ns/1ps
module transducer_driver_top (
  input  logic                                clk,
  input  logic                                arst_n,
  input  logic                                sync,
  input  logic                                wr_en,
  input  driver_pkg::addr_t                   wr_addr,
  input  driver_pkg::data_t                   wr_data,
  output logic [driver_pkg::NUM_CHANNELS-1:0] pwm_out,
  output driver_pkg::time_cnt_t               time_cnt,
  output logic                                update
);

  driver_pkg::channel_drive_t [driver_pkg::NUM_CHANNELS-1:0] channel_cfg;
  driver_pkg::drive_settings_t drive_cfg;
  driver_pkg::pulse_cmd_t      cmd;
  logic                        cmd_valid;

  driver_regs driver_regs (
    .clk        (clk),
    .arst_n     (arst_n),
    .wr_en      (wr_en),
    .wr_addr    (wr_addr),
    .wr_data    (wr_data),
    .channel_cfg(channel_cfg),
    .drive_cfg  (drive_cfg)
  );

  time_cnt_generator time_cnt_generator (
    .clk     (clk),
    .arst_n  (arst_n),
    .sync    (sync),
    .time_cnt(time_cnt),
    .update  (update)
  );

  intensity_modulator intensity_modulator (
    .clk        (clk),
    .arst_n     (arst_n),
    .update     (update),
    .channel_cfg(channel_cfg),
    .drive_cfg  (drive_cfg),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid)
  );

  pwm_generator pwm_generator (
    .clk      (clk),
    .arst_n   (arst_n),
    .time_cnt (time_cnt),
    .update   (update),
    .cmd      (cmd),
    .cmd_valid(cmd_valid),
    .pwm_out  (pwm_out)
  );

endmodule

//--- design/pwm_generator.sv
`timescale 1ns/1ps
module pwm_generator (
  input  logic                                  clk,
  input  logic                                  arst_n,
  input  driver_pkg::time_cnt_t                 time_cnt,
  input  logic                                  update,
  input  driver_pkg::pulse_cmd_t                cmd,
  input  logic                                  cmd_valid,
  output logic [driver_pkg::NUM_CHANNELS-1:0]   pwm_out
);

  driver_pkg::pulse_width_t shadow_width [driver_pkg::NUM_CHANNELS];
  driver_pkg::phase_t       shadow_phase [driver_pkg::NUM_CHANNELS];
  driver_pkg::pulse_width_t active_width [driver_pkg::NUM_CHANNELS];
  driver_pkg::phase_t       active_phase [driver_pkg::NUM_CHANNELS];

  driver_pkg::phase_t       rise_pt [driver_pkg::NUM_CHANNELS];
  driver_pkg::time_cnt_t    offset  [driver_pkg::NUM_CHANNELS];
  logic [driver_pkg::NUM_CHANNELS-1:0] pwm_next;

  // Incoming commands land in the shadow entry of their channel.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < driver_pkg::NUM_CHANNELS; i++) begin
        shadow_width[i] <= '0;
        shadow_phase[i] <= '0;
      end
    end else if (cmd_valid) begin
      shadow_width[cmd.chan] <= cmd.pulse_width;
      shadow_phase[cmd.chan] <= cmd.phase;
    end
  end

  // Update comes with time_cnt at 255, so the new values apply from 0.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < driver_pkg::NUM_CHANNELS; i++) begin
        active_width[i] <= '0;
        active_phase[i] <= '0;
      end
    end else if (update) begin
      for (int i = 0; i < driver_pkg::NUM_CHANNELS; i++) begin
        active_width[i] <= shadow_width[i];
        active_phase[i] <= shadow_phase[i];
      end
    end
  end

  // Window centred on the phase, wrapping mod 256.
  always_comb begin
    for (int i = 0; i < driver_pkg::NUM_CHANNELS; i++) begin
      rise_pt[i]  = active_phase[i] - (active_width[i] >> 1);
      offset[i]   = time_cnt - rise_pt[i];
      pwm_next[i] = (offset[i] < active_width[i]);
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      pwm_out <= '0;
    end else begin
      pwm_out <= pwm_next;
    end
  end

endmodule

//--- design/intensity_modulator.sv
`timescale 1ns/1ps
module intensity_modulator (
  input  logic                                                   clk,
  input  logic                                                   arst_n,
  input  logic                                                   update,
  input  driver_pkg::channel_drive_t [driver_pkg::NUM_CHANNELS-1:0] channel_cfg,
  input  driver_pkg::drive_settings_t                            drive_cfg,
  output driver_pkg::pulse_cmd_t                                 cmd,
  output logic                                                   cmd_valid
);

  typedef enum logic {
    IDLE,
    WALKING
  } state_t;

  localparam driver_pkg::chan_idx_t LAST_CHAN =
    driver_pkg::chan_idx_t'(driver_pkg::NUM_CHANNELS - 1);

  state_t state;
  driver_pkg::chan_idx_t chan_idx;

  // Stage one registers.
  logic                  s1_valid;
  logic [15:0]           s1_product;
  logic                  s1_enable;
  driver_pkg::phase_t    s1_phase;
  driver_pkg::chan_idx_t s1_chan;

  driver_pkg::channel_drive_t cur_cfg;

  assign cur_cfg = channel_cfg[chan_idx];

  // Channel walk, one channel per cycle after each update.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= IDLE;
      chan_idx <= '0;
    end else begin
      case (state)
        IDLE: begin
          if (update) begin
            state    <= WALKING;
            chan_idx <= '0;
          end
        end
        WALKING: begin
          if (chan_idx == LAST_CHAN) begin
            state <= IDLE;
          end
          chan_idx <= chan_idx + 1'b1;
        end
        default: state <= IDLE;
      endcase
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      s1_valid  <= 1'b0;
      cmd_valid <= 1'b0;
    end else begin
      s1_valid  <= (state == WALKING);
      cmd_valid <= s1_valid;
    end
  end

  // Max product is 255 * 256, so 16 bits hold it.
  always_ff @(posedge clk) begin
    s1_product <= {8'd0, cur_cfg.intensity} * ({8'd0, drive_cfg.mod_value} + 16'd1);
    s1_enable  <= drive_cfg.enable;
    s1_phase   <= cur_cfg.phase;
    s1_chan    <= chan_idx;
  end

  // Stage two: scale down and gate with enable.
  always_ff @(posedge clk) begin
    cmd.chan        <= s1_chan;
    cmd.pulse_width <= s1_enable ? s1_product[15:8] : '0;
    cmd.phase       <= s1_phase;
  end

endmodule

//--- design/time_cnt_generator.sv
`timescale 1ns/1ps
module time_cnt_generator (
  input  logic                  clk,
  input  logic                  arst_n,
  input  logic                  sync,
  output driver_pkg::time_cnt_t time_cnt,
  output logic                  update
);

  localparam driver_pkg::time_cnt_t LAST_BEFORE_END = 8'd254;

  logic update_next;

  // Update lines up with the final count of the period.
  // A sync jump never raises it.
  assign update_next = !sync && (time_cnt == LAST_BEFORE_END);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      time_cnt <= '0;
    end else if (sync) begin
      time_cnt <= '0;
    end else begin
      time_cnt <= time_cnt + 8'd1;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      update <= 1'b0;
    end else begin
      update <= update_next;
    end
  end

endmodule

//--- design/driver_regs.sv
`timescale 1ns/1ps
module driver_regs (
  input  logic                                                   clk,
  input  logic                                                   arst_n,
  input  logic                                                   wr_en,
  input  driver_pkg::addr_t                                      wr_addr,
  input  driver_pkg::data_t                                      wr_data,
  output driver_pkg::channel_drive_t [driver_pkg::NUM_CHANNELS-1:0] channel_cfg,
  output driver_pkg::drive_settings_t                            drive_cfg
);

  logic chan_hit;
  logic mod_hit;
  logic ctrl_hit;
  driver_pkg::chan_idx_t wr_chan;
  driver_pkg::channel_drive_t wr_entry;

  // Address decode.
  always_comb begin
    chan_hit = wr_en && (wr_addr < driver_pkg::addr_t'(driver_pkg::NUM_CHANNELS));
    mod_hit  = wr_en && (wr_addr == driver_pkg::MOD_ADDR);
    ctrl_hit = wr_en && (wr_addr == driver_pkg::CTRL_ADDR);
    wr_chan  = wr_addr[driver_pkg::CHAN_IDX_W-1:0];
  end

  // Intensity in the upper byte, phase in the lower.
  always_comb begin
    wr_entry.intensity = wr_data[15:8];
    wr_entry.phase     = wr_data[7:0];
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < driver_pkg::NUM_CHANNELS; i++) begin
        channel_cfg[i] <= '0;
      end
    end else if (chan_hit) begin
      channel_cfg[wr_chan] <= wr_entry;
    end
  end

  // Full scale modulation out of reset, output disabled.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      drive_cfg.mod_value <= 8'd255;
      drive_cfg.enable    <= 1'b0;
    end else begin
      if (mod_hit) begin
        drive_cfg.mod_value <= wr_data[7:0];
      end
      if (ctrl_hit) begin
        drive_cfg.enable <= wr_data[0];
      end
    end
  end

endmodule

//--- design/driver_pkg.sv
package driver_pkg;

  // Channel count of the array.
  localparam int NUM_CHANNELS = 4;
  localparam int CHAN_IDX_W = 2;

  typedef logic [7:0] addr_t;
  typedef logic [15:0] data_t;

  // Carrier time within one 256-cycle period.
  typedef logic [7:0] time_cnt_t;

  typedef logic [7:0] intensity_t;
  typedef logic [7:0] phase_t;
  typedef logic [7:0] pulse_width_t;
  typedef logic [CHAN_IDX_W-1:0] chan_idx_t;

  // Global register addresses, above the per-channel range.
  localparam addr_t MOD_ADDR = 8'd16;
  localparam addr_t CTRL_ADDR = 8'd17;

  typedef struct packed {
    intensity_t intensity;
    phase_t     phase;
  } channel_drive_t;

  typedef struct packed {
    logic [7:0] mod_value;
    logic       enable;
  } drive_settings_t;

  // One item of the modulator output stream.
  typedef struct packed {
    chan_idx_t    chan;
    pulse_width_t pulse_width;
    phase_t       phase;
  } pulse_cmd_t;

endpackage
